//--- design/flag_pkg.sv
package flag_pkg;

	// r0 layout, msb first
	// loads pick fields straight out of a data word with this layout
	typedef struct packed {
		logic       z;
		logic       m;
		logic       v;
		logic       c;
		logic       l;
		logic       e;
		logic       g;
		logic       y;
		logic       x;
		logic [6:0] user;
	} status_t;

	// flags out of the alu
	// each value has its own valid bit
	typedef struct packed {
		logic z;
		logic z_upd;
		logic m;
		logic m_upd;
		logic v;
		logic v_upd;
		logic c;
		logic c_upd;
		logic y;
		logic y_upd;
		logic x;
		logic x_upd;
	} arith_flags_t;

	// compare outcome, one hot
	typedef struct packed {
		logic l;
		logic e;
		logic g;
	} leg_t;

	// status register write enables
	typedef struct packed {
		logic zm;
		logic v;
		logic c;
		logic leg;
		logic y;
		logic x;
		logic ld_zmvc;
		logic ld_legy;
		logic ld_x;
		logic ld_user;
	} flag_upd_t;

endpackage

//--- design/cpu_pkg.sv
package cpu_pkg;

	// data path width
	localparam int WORD_W = 16;

	typedef logic [WORD_W-1:0] word_t;

	// operation codes
	typedef enum logic [3:0] {
		OP_ADD     = 4'd0,
		OP_SUB     = 4'd1,
		OP_AND     = 4'd2,
		OP_OR      = 4'd3,
		OP_XOR     = 4'd4,
		OP_SHL     = 4'd5,
		OP_SHR     = 4'd6,
		OP_CMP     = 4'd7,
		OP_LD_ZMVC = 4'd8,
		OP_LD_LEGY = 4'd9,
		OP_LD_X    = 4'd10,
		OP_LD_USER = 4'd11
	} op_t;

	// one queued command
	// loads take their value from a
	typedef struct packed {
		op_t   op;
		word_t a;
		word_t b;
	} cmd_t;

	// one returned result
	typedef struct packed {
		word_t             data;
		flag_pkg::status_t status;
	} res_t;

	// command queue size
	// also the number of credits upstream starts with
	localparam int CMD_DEPTH = 4;
	localparam int CMD_PTR_W = $clog2(CMD_DEPTH);
	localparam int CMD_CNT_W = $clog2(CMD_DEPTH + 1);

	// last slot index, for pointer wrap
	localparam logic [CMD_PTR_W-1:0] CMD_PTR_LAST = CMD_PTR_W'(CMD_DEPTH - 1);

	// result credits the stage holds after reset
	localparam int RES_CREDITS = 2;
	localparam int RES_CNT_W = $clog2(RES_CREDITS + 1);

endpackage

//--- design/alu_core.sv
`timescale 1ns/1ps

module alu_core (
	input  cpu_pkg::op_t           op,
	input  cpu_pkg::word_t         a,
	input  cpu_pkg::word_t         b,
	output cpu_pkg::word_t         y_word,
	output flag_pkg::arith_flags_t arith
);

	// subtract is a plus inverted b plus one
	logic                        sub;
	cpu_pkg::word_t              b_in;
	logic [cpu_pkg::WORD_W:0]    sum;
	logic                        is_add_sub;
	logic                        is_result_op;

	assign sub = (op == cpu_pkg::OP_SUB);
	assign b_in = sub ? ~b : b;
	assign sum = {1'b0, a} + {1'b0, b_in} + {{cpu_pkg::WORD_W{1'b0}}, sub};

	assign is_add_sub = (op == cpu_pkg::OP_ADD) || (op == cpu_pkg::OP_SUB);

	// ops whose result drives z and m
	always_comb begin
		case (op)
			cpu_pkg::OP_ADD, cpu_pkg::OP_SUB,
			cpu_pkg::OP_AND, cpu_pkg::OP_OR, cpu_pkg::OP_XOR,
			cpu_pkg::OP_SHL, cpu_pkg::OP_SHR:
				is_result_op = 1'b1;
			default:
				is_result_op = 1'b0;
		endcase
	end

	// result word
	always_comb begin
		case (op)
			cpu_pkg::OP_ADD,
			cpu_pkg::OP_SUB: y_word = sum[cpu_pkg::WORD_W-1:0];
			cpu_pkg::OP_AND: y_word = a & b;
			cpu_pkg::OP_OR:  y_word = a | b;
			cpu_pkg::OP_XOR: y_word = a ^ b;
			// shifts move one place, zero fill
			cpu_pkg::OP_SHL: y_word = {a[cpu_pkg::WORD_W-2:0], 1'b0};
			cpu_pkg::OP_SHR: y_word = {1'b0, a[cpu_pkg::WORD_W-1:1]};
			// compare and loads pass a
			default:         y_word = a;
		endcase
	end

	// flags
	always_comb begin
		arith = '0;

		// zero and minus from the result word
		arith.z     = (y_word == '0);
		arith.m     = y_word[cpu_pkg::WORD_W-1];
		arith.z_upd = is_result_op;
		arith.m_upd = is_result_op;

		// carry out of the adder
		arith.c     = sum[cpu_pkg::WORD_W];
		arith.c_upd = is_add_sub;

		// signed overflow
		// operands of equal sign giving a result of the other sign
		arith.v     = (a[cpu_pkg::WORD_W-1] == b_in[cpu_pkg::WORD_W-1]) &&
			(sum[cpu_pkg::WORD_W-1] != a[cpu_pkg::WORD_W-1]);
		arith.v_upd = is_add_sub;

		// bits pushed out by shifts
		arith.y     = a[cpu_pkg::WORD_W-1];
		arith.y_upd = (op == cpu_pkg::OP_SHL);
		arith.x     = a[0];
		arith.x_upd = (op == cpu_pkg::OP_SHR);
	end

endmodule

//--- design/cmp_unit.sv
`timescale 1ns/1ps

module cmp_unit (
	input  cpu_pkg::word_t  a,
	input  cpu_pkg::word_t  b,
	output flag_pkg::leg_t  leg
);

	logic lt;
	logic eq;

	// two's complement order
	assign lt = ($signed(a) < $signed(b));
	assign eq = (a == b);

	// exactly one bit set
	always_comb begin
		leg.l = lt;
		leg.e = eq;
		leg.g = ~lt & ~eq;
	end

endmodule

//--- design/status_reg.sv
`timescale 1ns/1ps

module status_reg (
	input  logic                   zer,
	input  logic                   w_zmvc,
	input  flag_pkg::flag_upd_t    flag_upd,
	input  flag_pkg::arith_flags_t arith,
	input  flag_pkg::leg_t         leg,
	input  cpu_pkg::word_t         load_word,
	output flag_pkg::status_t      status,
	output flag_pkg::status_t      status_next
);

	// load word seen through the r0 layout
	flag_pkg::status_t ld;

	assign ld = flag_pkg::status_t'(load_word);

	// next r0 from the enabled groups
	always_comb begin
		status_next = status;

		if (flag_upd.zm) begin
			status_next.z = arith.z;
			status_next.m = arith.m;
		end

		// overflow only ever sets from arithmetic
		if (flag_upd.v)
			status_next.v = status.v | arith.v;

		if (flag_upd.c)
			status_next.c = arith.c;

		if (flag_upd.leg) begin
			status_next.l = leg.l;
			status_next.e = leg.e;
			status_next.g = leg.g;
		end

		// shift out bits
		if (flag_upd.y)
			status_next.y = arith.y;
		if (flag_upd.x)
			status_next.x = arith.x;

		// explicit loads
		// zmvc load replaces a sticky v
		if (flag_upd.ld_zmvc) begin
			status_next.z = ld.z;
			status_next.m = ld.m;
			status_next.v = ld.v;
			status_next.c = ld.c;
		end

		if (flag_upd.ld_legy) begin
			status_next.l = ld.l;
			status_next.e = ld.e;
			status_next.g = ld.g;
			status_next.y = ld.y;
		end

		if (flag_upd.ld_x)
			status_next.x = ld.x;

		// user bits change here only
		if (flag_upd.ld_user)
			status_next.user = ld.user;
	end

	// r0 itself
	always_ff @(posedge zer or posedge w_zmvc) begin
		if (w_zmvc) begin
			status <= '0;
		end else begin
			status <= status_next;
		end
	end

endmodule

//--- design/cmd_queue.sv
`timescale 1ns/1ps

module cmd_queue (
	input  logic          zer,
	input  logic          w_zmvc,
	input  logic          push,
	input  cpu_pkg::cmd_t push_cmd,
	input  logic          pop,
	output cpu_pkg::cmd_t head,
	output logic          not_empty,
	output logic          credit
);

	// entry storage
	cpu_pkg::cmd_t mem [cpu_pkg::CMD_DEPTH];

	logic [cpu_pkg::CMD_PTR_W-1:0] wr_ptr;
	logic [cpu_pkg::CMD_PTR_W-1:0] rd_ptr;
	logic [cpu_pkg::CMD_CNT_W-1:0] count;

	// credits keep upstream from ever pushing into a full queue
	always_ff @(posedge zer) begin
		if (push)
			mem[wr_ptr] <= push_cmd;
	end

	// pointers and occupancy
	always_ff @(posedge zer or posedge w_zmvc) begin
		if (w_zmvc) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push)
				wr_ptr <= (wr_ptr == cpu_pkg::CMD_PTR_LAST) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == cpu_pkg::CMD_PTR_LAST) ? '0 : rd_ptr + 1'b1;
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// one credit per freed slot, the cycle after the pop
	always_ff @(posedge zer or posedge w_zmvc) begin
		if (w_zmvc)
			credit <= 1'b0;
		else
			credit <= pop;
	end

	assign head = mem[rd_ptr];
	assign not_empty = (count != '0);

endmodule

//--- design/exec_stage.sv
`timescale 1ns/1ps

module exec_stage (
	input  logic                   zer,
	input  logic                   w_zmvc,
	input  cpu_pkg::cmd_t          head,
	input  logic                   not_empty,
	input  logic                   res_credit,
	input  flag_pkg::status_t      status,
	input  flag_pkg::status_t      status_next,
	output logic                   pop,
	output flag_pkg::flag_upd_t    flag_upd,
	output flag_pkg::arith_flags_t arith,
	output flag_pkg::leg_t         leg,
	output cpu_pkg::word_t         load_word,
	output logic                   res_valid,
	output cpu_pkg::res_t          res
);

	logic [cpu_pkg::RES_CNT_W-1:0] credits;
	cpu_pkg::word_t                y_word;

	alu_core u_alu (
		.op     (head.op),
		.a      (head.a),
		.b      (head.b),
		.y_word (y_word),
		.arith  (arith)
	);

	cmp_unit u_cmp (
		.a   (head.a),
		.b   (head.b),
		.leg (leg)
	);

	// issue when a command waits and downstream has room
	assign pop = not_empty && (credits != '0);

	// loads take their value from a
	assign load_word = head.a;

	// result credits, spent on issue and refilled by downstream
	always_ff @(posedge zer or posedge w_zmvc) begin
		if (w_zmvc) begin
			credits <= cpu_pkg::RES_CNT_W'(cpu_pkg::RES_CREDITS);
		end else begin
			case ({pop, res_credit})
				2'b10:   credits <= credits - 1'b1;
				2'b01:   credits <= credits + 1'b1;
				default: credits <= credits;
			endcase
		end
	end

	// group enables, only for an issued command
	always_comb begin
		flag_upd = '0;
		flag_upd.zm  = pop & arith.z_upd & arith.m_upd;
		// v is sticky so only a fresh overflow needs a write
		flag_upd.v   = pop & arith.v_upd & arith.v & ~status.v;
		flag_upd.c   = pop & arith.c_upd;
		flag_upd.leg = pop & (head.op == cpu_pkg::OP_CMP);
		flag_upd.y   = pop & arith.y_upd;
		flag_upd.x   = pop & arith.x_upd;
		case (head.op)
			cpu_pkg::OP_LD_ZMVC: flag_upd.ld_zmvc = pop;
			cpu_pkg::OP_LD_LEGY: flag_upd.ld_legy = pop;
			cpu_pkg::OP_LD_X:    flag_upd.ld_x    = pop;
			cpu_pkg::OP_LD_USER: flag_upd.ld_user = pop;
			default: ;
		endcase
	end

	// result valid, one per issue
	always_ff @(posedge zer or posedge w_zmvc) begin
		if (w_zmvc)
			res_valid <= 1'b0;
		else
			res_valid <= pop;
	end

	// result payload
	// status is the same value r0 takes at this edge
	always_ff @(posedge zer) begin
		if (pop) begin
			res.data   <= y_word;
			res.status <= status_next;
		end
	end

endmodule

//--- design/exec_slice.sv
`timescale 1ns/1ps

module exec_slice (
	input  logic          zer,
	input  logic          w_zmvc,
	input  logic          cmd_valid,
	input  cpu_pkg::cmd_t cmd,
	input  logic          res_credit,
	output logic          cmd_credit,
	output logic          res_valid,
	output cpu_pkg::res_t res
);

	// queue to stage
	cpu_pkg::cmd_t head;
	logic          not_empty;
	logic          pop;

	// stage to status register and back
	flag_pkg::flag_upd_t    flag_upd;
	flag_pkg::arith_flags_t arith;
	flag_pkg::leg_t         leg;
	cpu_pkg::word_t         load_word;
	flag_pkg::status_t      status;
	flag_pkg::status_t      status_next;

	cmd_queue u_queue (
		.zer       (zer),
		.w_zmvc    (w_zmvc),
		.push      (cmd_valid),
		.push_cmd  (cmd),
		.pop       (pop),
		.head      (head),
		.not_empty (not_empty),
		.credit    (cmd_credit)
	);

	exec_stage u_stage (
		.zer         (zer),
		.w_zmvc      (w_zmvc),
		.head        (head),
		.not_empty   (not_empty),
		.res_credit  (res_credit),
		.status      (status),
		.status_next (status_next),
		.pop         (pop),
		.flag_upd    (flag_upd),
		.arith       (arith),
		.leg         (leg),
		.load_word   (load_word),
		.res_valid   (res_valid),
		.res         (res)
	);

	status_reg u_r0 (
		.zer         (zer),
		.w_zmvc      (w_zmvc),
		.flag_upd    (flag_upd),
		.arith       (arith),
		.leg         (leg),
		.load_word   (load_word),
		.status      (status),
		.status_next (status_next)
	);

endmodule

//--- verification/exec_slice_chk.sv
`timescale 1ns/1ps

module exec_slice_chk (
	input logic                zer,
	input logic                w_zmvc,
	input logic                cmd_valid,
	input logic                cmd_credit,
	input logic                res_valid,
	input logic                res_credit,
	input flag_pkg::status_t   status,
	input flag_pkg::flag_upd_t flag_upd
);

	// credits as upstream and downstream hold them
	int cmd_avail;
	int res_avail;
	// count of failed assertions
	int fails = 0;

	always_ff @(posedge zer or posedge w_zmvc) begin
		if (w_zmvc) begin
			cmd_avail <= cpu_pkg::CMD_DEPTH;
			res_avail <= cpu_pkg::RES_CREDITS;
		end else begin
			cmd_avail <= cmd_avail - int'(cmd_valid) + int'(cmd_credit);
			res_avail <= res_avail - int'(res_valid) + int'(res_credit);
		end
	end

	// r0 clear and outputs quiet while reset is held
	a_reset_state: assert property (@(posedge zer)
		w_zmvc |-> (status == '0 && !res_valid && !cmd_credit))
		else begin
			fails++;
			$error("r0 or outputs not idle during reset");
		end

	// upstream only sends on a held credit
	a_cmd_spend: assert property (@(posedge zer) disable iff (w_zmvc)
		cmd_valid |-> (cmd_avail > 0))
		else begin
			fails++;
			$error("command accepted without a credit");
		end

	// never more credits back than slots in the queue
	a_cmd_return: assert property (@(posedge zer) disable iff (w_zmvc)
		cmd_credit |-> (cmd_avail < cpu_pkg::CMD_DEPTH))
		else begin
			fails++;
			$error("command credit returned beyond queue depth");
		end

	// results stay within granted credits
	a_res_spend: assert property (@(posedge zer) disable iff (w_zmvc)
		res_valid |-> (res_avail > 0))
		else begin
			fails++;
			$error("result sent without a result credit");
		end

	// v only drops through a zmvc load
	a_sticky_v: assert property (@(posedge zer) disable iff (w_zmvc)
		(status.v && !flag_upd.ld_zmvc) |=> status.v)
		else begin
			fails++;
			$error("sticky v cleared without a load");
		end

endmodule

bind exec_slice exec_slice_chk u_chk (
	.zer        (zer),
	.w_zmvc     (w_zmvc),
	.cmd_valid  (cmd_valid),
	.cmd_credit (cmd_credit),
	.res_valid  (res_valid),
	.res_credit (res_credit),
	.status     (status),
	.flag_upd   (flag_upd)
);

//--- include/exec_model.svh
`ifndef EXEC_MODEL_SVH
`define EXEC_MODEL_SVH

// reference model of one command
// updates r0 in place and returns the expected result
function automatic cpu_pkg::res_t exec_model_step(
	input cpu_pkg::cmd_t         cmd,
	inout flag_pkg::status_t     r0
);
	cpu_pkg::res_t               res;
	cpu_pkg::word_t              a;
	cpu_pkg::word_t              b;
	cpu_pkg::word_t              d;
	logic [cpu_pkg::WORD_W:0]    sum;
	logic                        ovf;
	int                          sa;
	int                          sb;
	int                          sr;
	flag_pkg::status_t           ld;

	a = cmd.a;
	b = cmd.b;
	d = a;
	ld = flag_pkg::status_t'(a);
	// operands as signed integers
	sa = $signed(a);
	sb = $signed(b);

	case (cmd.op)
		cpu_pkg::OP_ADD, cpu_pkg::OP_SUB: begin
			if (cmd.op == cpu_pkg::OP_SUB)
				b = ~b;
			sum = {1'b0, a} + {1'b0, b} + (cmd.op == cpu_pkg::OP_SUB);
			d = sum[cpu_pkg::WORD_W-1:0];
			// true signed result outside the 16 bit range
			sr = (cmd.op == cpu_pkg::OP_SUB) ? sa - sb : sa + sb;
			ovf = (sr > 32767) || (sr < -32768);
			r0.c = sum[cpu_pkg::WORD_W];
			// sticky overflow
			r0.v = r0.v | ovf;
		end
		cpu_pkg::OP_AND: d = a & b;
		cpu_pkg::OP_OR:  d = a | b;
		cpu_pkg::OP_XOR: d = a ^ b;
		cpu_pkg::OP_SHL: begin
			d = {a[14:0], 1'b0};
			r0.y = a[15];
		end
		cpu_pkg::OP_SHR: begin
			d = {1'b0, a[15:1]};
			r0.x = a[0];
		end
		cpu_pkg::OP_CMP: begin
			r0.l = ($signed(a) < $signed(b));
			r0.e = (a == b);
			r0.g = ($signed(a) > $signed(b));
		end
		cpu_pkg::OP_LD_ZMVC: begin
			r0.z = ld.z;
			r0.m = ld.m;
			r0.v = ld.v;
			r0.c = ld.c;
		end
		cpu_pkg::OP_LD_LEGY: begin
			r0.l = ld.l;
			r0.e = ld.e;
			r0.g = ld.g;
			r0.y = ld.y;
		end
		cpu_pkg::OP_LD_X:    r0.x = ld.x;
		cpu_pkg::OP_LD_USER: r0.user = ld.user;
		default: ;
	endcase

	// z and m follow every result op
	if (cmd.op <= cpu_pkg::OP_SHR) begin
		r0.z = (d == '0);
		r0.m = d[15];
	end

	res.data = d;
	res.status = r0;
	return res;
endfunction

`endif

//--- verification/exec_tb.sv
`timescale 1ns/1ps

module exec_tb;

	localparam logic [31:0] SEED = 32'h63aaa49c;

	// commands per test
	localparam int N_ARITH = 60;
	localparam int N_LOGIC = 60;
	localparam int N_CMP   = 40;
	localparam int N_LOAD  = 40;
	localparam int N_FLOW  = 80;
	localparam int N_RESET = 30;
	localparam int TOTAL_CMDS = N_ARITH + N_LOGIC + N_CMP + N_LOAD + N_FLOW + N_RESET;
	localparam int CYCLE_LIMIT = 4 * TOTAL_CMDS + 200;

	// stimulus mixes
	localparam int KIND_ARITH = 0;
	localparam int KIND_LOGIC = 1;
	localparam int KIND_CMP   = 2;
	localparam int KIND_LOAD  = 3;
	localparam int KIND_ANY   = 4;

	logic          zer;
	logic          w_zmvc;
	logic          cmd_valid;
	cpu_pkg::cmd_t cmd;
	logic          res_credit;
	logic          cmd_credit;
	logic          res_valid;
	cpu_pkg::res_t res;

	// model state and expected results in order
	flag_pkg::status_t model_r0;
	cpu_pkg::res_t     exp_q[$];

	// upstream and downstream bookkeeping
	int cmd_cred;
	int credit_pulses;
	int accepted;
	int owed;
	int res_avail;
	int stall_left;
	bit stall_en;
	int cycles;

	string cur_test;
	int    test_errs;
	int    tests_passed;
	int    tests_failed;

	`include "exec_model.svh"

	exec_slice UUT (
		.zer        (zer),
		.w_zmvc     (w_zmvc),
		.cmd_valid  (cmd_valid),
		.cmd        (cmd),
		.res_credit (res_credit),
		.cmd_credit (cmd_credit),
		.res_valid  (res_valid),
		.res        (res)
	);

	always #4 zer = ~zer;

	task automatic check_word(input string name, input cpu_pkg::word_t exp,
		input cpu_pkg::word_t act);
		if (exp !== act) begin
			$display("error %s: data expected %h actual %h", name, exp, act);
			test_errs++;
		end
	endtask

	task automatic check_status(input string name, input flag_pkg::status_t exp,
		input flag_pkg::status_t act);
		if (exp !== act) begin
			$display("error %s: status expected %b actual %b", name, exp, act);
			test_errs++;
		end
	endtask

	task automatic check_count(input string name, input string what, input int exp,
		input int act);
		if (exp != act) begin
			$display("error %s: %s expected %0d actual %0d", name, what, exp, act);
			test_errs++;
		end
	endtask

	// one random command of the given mix
	function automatic cpu_pkg::cmd_t random_cmd(input int kind);
		cpu_pkg::cmd_t c;
		int            pick;
		c.a = cpu_pkg::word_t'($urandom);
		c.b = cpu_pkg::word_t'($urandom);
		pick = $urandom_range(7);
		case (kind)
			KIND_ARITH: c.op = pick[0] ? cpu_pkg::OP_SUB : cpu_pkg::OP_ADD;
			// an add now and then so c and v hold something
			KIND_LOGIC: c.op = (pick == 0) ? cpu_pkg::OP_ADD : cpu_pkg::op_t'(2 + pick % 5);
			KIND_CMP: begin
				c.op = (pick == 0) ? cpu_pkg::OP_SHL : cpu_pkg::OP_CMP;
				// equal operands a quarter of the time
				if (pick == 1 || pick == 2)
					c.b = c.a;
			end
			KIND_LOAD:  c.op = (pick == 0) ? cpu_pkg::OP_ADD : cpu_pkg::op_t'(8 + pick % 4);
			default:    c.op = cpu_pkg::op_t'($urandom_range(11));
		endcase
		return c;
	endfunction

	// upstream sends only while holding a credit
	task automatic send_commands(input int n, input int kind);
		int            sent;
		cpu_pkg::cmd_t c;
		sent = 0;
		while (sent < n) begin
			@(posedge zer);
			#1;
			cmd_valid = 1'b0;
			if (cmd_cred > 0 && $urandom_range(3) != 0) begin
				c = random_cmd(kind);
				// arithmetic run starts from a clear v
				if (kind == KIND_ARITH && sent == 0) begin
					c.op = cpu_pkg::OP_LD_ZMVC;
					c.a = '0;
				end
				cmd = c;
				cmd_valid = 1'b1;
				cmd_cred--;
				accepted++;
				sent++;
				exp_q.push_back(exec_model_step(c, model_r0));
			end
		end
		@(posedge zer);
		#1;
		cmd_valid = 1'b0;
	endtask

	// wait until every expected result has arrived
	// the last credit pulse comes with the last result
	task automatic wait_drain();
		while (exp_q.size() != 0)
			@(negedge zer);
	endtask

	task automatic run_test(input string name, input int kind, input int n, input bit stalls);
		cur_test = name;
		test_errs = 0;
		stall_en = stalls;
		send_commands(n, kind);
		wait_drain();
		stall_en = 1'b0;
		check_count(name, "command credits", accepted, credit_pulses);
		if (test_errs == 0) begin
			tests_passed++;
			$display("test %s: %0d commands, pass", name, n);
		end else begin
			tests_failed++;
			$display("test %s: %0d commands, %0d errors", name, n, test_errs);
		end
	endtask

	// reset in mid run so model and credits start over
	task automatic apply_reset();
		@(posedge zer);
		#2;
		w_zmvc = 1'b1;
		cmd_valid = 1'b0;
		model_r0 = '0;
		cmd_cred = cpu_pkg::CMD_DEPTH;
		credit_pulses = 0;
		accepted = 0;
		owed = 0;
		res_avail = cpu_pkg::RES_CREDITS;
		stall_left = 0;
		exp_q.delete();
		repeat (2) @(posedge zer);
		#1;
		w_zmvc = 1'b0;
	endtask

	// queue credits coming back
	always @(posedge zer) begin
		if (!w_zmvc && cmd_credit) begin
			cmd_cred++;
			credit_pulses++;
		end
	end

	// result collection and compare
	always @(posedge zer) begin : collect
		cpu_pkg::res_t exp;
		if (!w_zmvc && res_valid) begin
			owed++;
			if (res_avail == 0) begin
				$display("test %s: result arrived with no result credit granted", cur_test);
				test_errs++;
			end else begin
				res_avail--;
			end
			if (exp_q.size() == 0) begin
				$display("test %s: result arrived with no command outstanding", cur_test);
				test_errs++;
			end else begin
				exp = exp_q.pop_front();
				check_word(cur_test, exp.data, res.data);
				check_status(cur_test, exp.status, res.status);
			end
		end
	end

	// downstream returns credits late and stalls in stretches when enabled
	always begin
		@(posedge zer);
		#1;
		res_credit = 1'b0;
		if (stall_left > 0) begin
			stall_left--;
		end else if (stall_en && $urandom_range(31) == 0) begin
			stall_left = $urandom_range(12, 3);
		end else if (owed > 0 && $urandom_range(9) < 7) begin
			res_credit = 1'b1;
			owed--;
			res_avail++;
		end
	end

	// run limit
	always @(posedge zer) begin
		cycles++;
		if (cycles > CYCLE_LIMIT) begin
			$display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("CHECKS FAILED");
			$finish;
		end
	end

	initial begin
		void'($urandom(SEED));
		zer = 1'b0;
		w_zmvc = 1'b0;
		cmd_valid = 1'b0;
		cmd = '0;
		res_credit = 1'b0;
		model_r0 = '0;
		cmd_cred = cpu_pkg::CMD_DEPTH;
		credit_pulses = 0;
		accepted = 0;
		owed = 0;
		res_avail = cpu_pkg::RES_CREDITS;
		stall_left = 0;
		stall_en = 1'b0;
		cycles = 0;
		cur_test = "startup";
		test_errs = 0;
		tests_passed = 0;
		tests_failed = 0;
		// reset rises once the clock and inputs are settled
		#1;
		w_zmvc = 1'b1;
		repeat (2) @(posedge zer);
		#1;
		w_zmvc = 1'b0;

		run_test("arith", KIND_ARITH, N_ARITH, 1'b0);
		run_test("logic_shift", KIND_LOGIC, N_LOGIC, 1'b0);
		run_test("compare", KIND_CMP, N_CMP, 1'b0);
		run_test("loads", KIND_LOAD, N_LOAD, 1'b0);
		run_test("flow", KIND_ANY, N_FLOW, 1'b1);
		// r0 holds loaded bits here so the first result after reset shows the clear
		apply_reset();
		run_test("reset", KIND_ANY, N_RESET, 1'b0);

		$display("tests passed %0d failed %0d, assertion failures %0d",
			tests_passed, tests_failed, UUT.u_chk.fails);
		if (tests_failed == 0 && UUT.u_chk.fails == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

//--- exec_slice.f
design/flag_pkg.sv
design/cpu_pkg.sv
design/alu_core.sv
design/cmp_unit.sv
design/status_reg.sv
design/cmd_queue.sv
design/exec_stage.sv
design/exec_slice.sv
+incdir+include
verification/exec_slice_chk.sv
verification/exec_tb.sv
